//--- project.f
+incdir+verilog
verilog/bt_pkg.sv
verilog/bt_uart_rx.sv
verilog/bt_rx_fifo.sv
verilog/bt_uart_tx.sv
verilog/bt_host_endpoints.sv
verilog/fpga_bluetooth_connection.sv
testbench/tb_fpga_bluetooth_connection.sv

//--- run.sh
#!/bin/sh
# build and run the Bluetooth link testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_fpga_bluetooth_connection -f project.f
./obj_dir/Vtb_fpga_bluetooth_connection

//--- testbench/tb_fpga_bluetooth_connection.sv
/*
 Testbench for the Bluetooth serial link top level
 sends LFSR driven UART frames and host triggers, checks both
 wire-out words and the transmit line against a reference model
*/
`timescale 1ns/10ps
`include "bt_settings.svh"

module tb_fpga_bluetooth_connection import bt_pkg::*; ();

	localparam int CLKS  = `BT_CLKS_PER_BIT;
	localparam int DEPTH = `BT_RX_FIFO_DEPTH;

	logic        clock;
	logic        arst_n;
	logic        bt_state;
	logic        fpga_rxd;
	logic        bt_enable;
	logic        fpga_txd;
	logic [15:0] ep01_wire_in;
	logic [15:0] ep40_trig_in;
	logic [15:0] ep20_wire_out;
	logic [15:0] ep21_wire_out;
	logic [31:0] lfsr;

	// reference model
	bt_byte_t    exp_q[$];
	logic        exp_overflow;
	logic        exp_frame_error;
	logic        exp_tx_dropped;
	logic        exp_tx_busy;
	logic        exp_enable;
	logic        exp_bt_state;

	fpga_bluetooth_connection DUT (
		.clock         (clock),
		.arst_n        (arst_n),
		.bt_state      (bt_state),
		.fpga_rxd      (fpga_rxd),
		.bt_enable     (bt_enable),
		.fpga_txd      (fpga_txd),
		.ep01_wire_in  (ep01_wire_in),
		.ep40_trig_in  (ep40_trig_in),
		.ep20_wire_out (ep20_wire_out),
		.ep21_wire_out (ep21_wire_out)
	);

	// 20 ns clock
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// status word the host should see
	function automatic bt_status_t model_status();
		bt_status_t s;
		s             = '0;
		s.bt_state    = exp_bt_state;
		s.bt_enable   = exp_enable;
		s.tx_busy     = exp_tx_busy;
		s.fifo_empty  = (exp_q.size() == 0);
		s.fifo_full   = (exp_q.size() == DEPTH);
		s.overflow    = exp_overflow;
		s.frame_error = exp_frame_error;
		s.tx_dropped  = exp_tx_dropped;
		return s;
	endfunction

	task automatic stop_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic timed_out(input string what);
		$display("Timeout: %s never came", what);
		stop_run();
	endtask

	task automatic check_byte(input string name, input bt_byte_t got, input bt_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %02h expected %02h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %02h expected %02h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_status(input string name, input bt_status_t got,
		input bt_status_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %04h expected %04h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %01h expected %01h", name, got, exp);
			stop_run();
		end
	endtask

	// inputs change and outputs are read 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic pulse_trigger(input host_trig_t t);
		ep40_trig_in = 16'd1 << t;
		next_cycle();
		ep40_trig_in = '0;
	endtask

	task automatic wait_count(input logic [7:0] exp, input int limit, input string what);
		int n;
		n = 0;
		while (ep20_wire_out[7:0] !== exp) begin
			if (n == limit)
				timed_out(what);
			next_cycle();
			n++;
		end
	endtask

	// waits until the masked status fields match the model
	task automatic wait_status(input bt_status_t mask, input int limit, input string what);
		int n;
		n = 0;
		while ((ep21_wire_out & mask) !== (model_status() & mask)) begin
			if (n == limit)
				timed_out(what);
			next_cycle();
			n++;
		end
	endtask

	// one uart frame on fpga_rxd with data LSB first
	task automatic send_frame(input bt_byte_t b, input logic stop_bit);
		fpga_rxd = 1'b0;
		repeat (CLKS) next_cycle();
		for (int i = 0; i < 8; i++) begin
			fpga_rxd = b[i];
			repeat (CLKS) next_cycle();
		end
		fpga_rxd = stop_bit;
		repeat (CLKS) next_cycle();
		fpga_rxd = 1'b1;
	endtask

	// full fifo drops the byte and raises overflow
	task automatic receive_byte(input bt_byte_t b);
		send_frame(b, 1'b1);
		if (exp_q.size() < DEPTH) begin
			exp_q.push_back(b);
			wait_count(8'(exp_q.size()), 16, "fifo count after receive");
		end else begin
			exp_overflow = 1'b1;
		end
	endtask

	task automatic pop_and_check();
		check_byte("ep20_wire_out head", ep20_wire_out[15:8], exp_q[0]);
		pulse_trigger(TRIG_POP);
		void'(exp_q.pop_front());
		wait_count(8'(exp_q.size()), 8, "fifo count after pop");
		check_status("ep21_wire_out", ep21_wire_out, model_status());
	endtask

	// samples fpga_txd at mid-bit and may send again during data bit 0
	task automatic decode_tx_frame(input logic send_again, output bt_byte_t b);
		int n;
		int slot;
		int cyc;
		n = 0;
		b = '0;
		while (fpga_txd !== 1'b0) begin
			if (n == 4)
				timed_out("start bit on fpga_txd");
			next_cycle();
			n++;
		end
		for (int i = 0; i < 10 * CLKS; i++) begin
			if (i > 0)
				next_cycle();
			slot = i / CLKS;
			cyc  = i % CLKS;
			if (send_again && slot == 1 && cyc == 0) begin
				ep01_wire_in[7:0] = ~ep01_wire_in[7:0];
				ep40_trig_in      = 16'd1 << TRIG_SEND;
				exp_tx_dropped    = 1'b1;
			end else if (slot == 1 && cyc == 1) begin
				ep40_trig_in = '0;
			end
			if (cyc == CLKS / 2) begin
				// busy for the whole frame
				check_status("ep21_wire_out", ep21_wire_out, model_status());
				if (slot == 0)
					check_bit("fpga_txd start bit", fpga_txd, 1'b0);
				else if (slot == 9)
					check_bit("fpga_txd stop bit", fpga_txd, 1'b1);
				else
					b = {fpga_txd, b[7:1]};
			end
		end
	endtask

	initial begin
		bt_status_t m;
		bt_byte_t   b;
		bt_byte_t   got;
		logic [31:0] r;
		int         n;

		arst_n          = 1'b0;
		fpga_rxd        = 1'b1;
		bt_state        = 1'b0;
		ep01_wire_in    = '0;
		ep40_trig_in    = '0;
		lfsr            = 32'hf682_c05d;
		exp_overflow    = 1'b0;
		exp_frame_error = 1'b0;
		exp_tx_dropped  = 1'b0;
		exp_tx_busy     = 1'b0;
		exp_enable      = 1'b0;
		exp_bt_state    = 1'b0;
		repeat (10) @(posedge clock);
		#2;
		arst_n = 1'b1;
		next_cycle();

		// reset state
		check_status("ep21_wire_out", ep21_wire_out, model_status());
		check_count("ep20_wire_out count", ep20_wire_out[7:0], 8'd0);
		check_bit("fpga_txd", fpga_txd, 1'b1);

		// receive a random number of bytes and drain them in order
		r = random_bits(8);
		n = 1 + int'(r % DEPTH);
		for (int i = 0; i < n; i++) begin
			r = random_bits(8);
			receive_byte(r[7:0]);
		end
		check_status("ep21_wire_out", ep21_wire_out, model_status());
		while (exp_q.size() > 0)
			pop_and_check();

		// overflow by two frames past full
		for (int i = 0; i < DEPTH + 2; i++) begin
			r = random_bits(8);
			receive_byte(r[7:0]);
		end
		m          = '0;
		m.overflow = 1'b1;
		wait_status(m, 16, "overflow flag");
		check_count("ep20_wire_out count", ep20_wire_out[7:0], 8'(DEPTH));
		check_status("ep21_wire_out", ep21_wire_out, model_status());
		while (exp_q.size() > 0)
			pop_and_check();
		pulse_trigger(TRIG_CLEAR);
		exp_overflow = 1'b0;
		wait_status(m, 4, "overflow clear");
		check_status("ep21_wire_out", ep21_wire_out, model_status());

		// low stop bit raises frame error and leaves the count alone
		r = random_bits(8);
		receive_byte(r[7:0]);
		r = random_bits(8);
		send_frame(r[7:0], 1'b0);
		// idle line lets the receiver drop the false start
		repeat (2 * CLKS) next_cycle();
		exp_frame_error = 1'b1;
		m               = '0;
		m.frame_error   = 1'b1;
		wait_status(m, 16, "frame error flag");
		check_count("ep20_wire_out count", ep20_wire_out[7:0], 8'(exp_q.size()));
		check_status("ep21_wire_out", ep21_wire_out, model_status());
		pop_and_check();
		pulse_trigger(TRIG_CLEAR);
		exp_frame_error = 1'b0;
		wait_status(m, 4, "frame error clear");

		// transmit one byte and drop a second send during the frame
		r                 = random_bits(8);
		b                 = r[7:0];
		ep01_wire_in[7:0] = b;
		pulse_trigger(TRIG_SEND);
		exp_tx_busy = 1'b1;
		decode_tx_frame(1'b1, got);
		check_byte("fpga_txd frame", got, b);
		exp_tx_busy = 1'b0;
		m           = '0;
		m.tx_busy   = 1'b1;
		wait_status(m, 2 * CLKS, "tx_busy release");
		check_status("ep21_wire_out", ep21_wire_out, model_status());
		check_bit("fpga_txd", fpga_txd, 1'b1);
		pulse_trigger(TRIG_CLEAR);
		exp_tx_dropped = 1'b0;
		m              = '0;
		m.tx_dropped   = 1'b1;
		wait_status(m, 4, "tx dropped clear");

		// enable latch and module state pin
		for (int i = 0; i < 4; i++) begin
			r               = random_bits(1);
			ep01_wire_in[8] = r[0];
			pulse_trigger(TRIG_ENABLE_LATCH);
			exp_enable = r[0];
			// bit 8 changes without a trigger and bt_enable holds
			ep01_wire_in[8] = ~r[0];
			check_bit("bt_enable", bt_enable, exp_enable);
			m           = '0;
			m.bt_enable = 1'b1;
			wait_status(m, 4, "bt_enable in status");
			r            = random_bits(1);
			bt_state     = r[0];
			exp_bt_state = r[0];
			m            = '0;
			m.bt_state   = 1'b1;
			// synchroniser plus output register
			wait_status(m, 3, "bt_state in status");
			check_status("ep21_wire_out", ep21_wire_out, model_status());
			check_bit("bt_enable", bt_enable, exp_enable);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

//--- verilog/bt_host_endpoints.sv
/*
 Host endpoint block
 decodes host trigger pulses into pop and send strobes, holds the
 module enable and sticky error flags, builds both wire-out words
*/
`timescale 1ns/10ps

module bt_host_endpoints import bt_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  logic [15:0] ep01_wire_in,
	input  logic [15:0] ep40_trig_in,
	input  logic        bt_state,
	input  bt_byte_t    head_byte,
	input  logic [7:0]  count,
	input  logic        empty,
	input  logic        full,
	input  logic        overflow_pulse,
	input  logic        frame_error_pulse,
	input  logic        tx_busy,
	output logic        pop,
	output logic        tx_start,
	output bt_byte_t    tx_byte,
	output logic        bt_enable,
	output logic [15:0] ep20_wire_out,
	output logic [15:0] ep21_wire_out
);

	logic       trig_send;
	logic       trig_pop;
	logic       trig_clear;
	logic       trig_enable;
	logic       send_ok;
	logic       pop_ok;
	logic       state_meta;
	logic       state_s;
	logic       overflow;
	logic       frame_error;
	logic       tx_dropped;
	bt_status_t status;

	assign trig_send   = ep40_trig_in[TRIG_SEND];
	assign trig_pop    = ep40_trig_in[TRIG_POP];
	assign trig_clear  = ep40_trig_in[TRIG_CLEAR];
	assign trig_enable = ep40_trig_in[TRIG_ENABLE_LATCH];

	// tx_busy rises one cycle after tx_start, cover that gap
	assign send_ok = trig_send && !tx_busy && !tx_start;
	// last entry may already be leaving on this edge
	assign pop_ok  = trig_pop && !empty && !(pop && count == 8'd1);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pop         <= 1'b0;
			tx_start    <= 1'b0;
			bt_enable   <= 1'b0;
			state_meta  <= 1'b0;
			state_s     <= 1'b0;
			overflow    <= 1'b0;
			frame_error <= 1'b0;
			tx_dropped  <= 1'b0;
		end else begin
			pop        <= pop_ok;
			tx_start   <= send_ok;
			// module pin is asynchronous
			state_meta <= bt_state;
			state_s    <= state_meta;
			if (trig_enable)
				bt_enable <= ep01_wire_in[8];
			// a new event in the clear cycle still sticks
			overflow    <= (overflow && !trig_clear) || overflow_pulse;
			frame_error <= (frame_error && !trig_clear) || frame_error_pulse;
			tx_dropped  <= (tx_dropped && !trig_clear) || (trig_send && !send_ok);
		end
	end

	// transmit byte, latched with the send
	always_ff @(posedge clock) begin
		if (send_ok)
			tx_byte <= ep01_wire_in[7:0];
	end

	always_comb begin
		status             = '0;
		status.bt_state    = state_s;
		status.bt_enable   = bt_enable;
		status.tx_busy     = tx_busy;
		status.fifo_empty  = empty;
		status.fifo_full   = full;
		status.overflow    = overflow;
		status.frame_error = frame_error;
		status.tx_dropped  = tx_dropped;
	end

	// registered wire-out words
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			ep20_wire_out <= '0;
			ep21_wire_out <= '0;
		end else begin
			ep20_wire_out <= {head_byte, count};
			ep21_wire_out <= status;
		end
	end

endmodule

//--- verilog/bt_pkg.sv
/*
 Bluetooth serial link types
 data byte, host status word, FSM states and trigger bit positions
*/
package bt_pkg;

	// one uart data byte
	typedef logic [7:0] bt_byte_t;

	// status word on ep21, bt_state in bit 0
	typedef struct packed {
		logic [7:0] reserved;
		logic       tx_dropped;
		logic       frame_error;
		logic       overflow;
		logic       fifo_full;
		logic       fifo_empty;
		logic       tx_busy;
		logic       bt_enable;
		logic       bt_state;
	} bt_status_t;

	// receiver FSM
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	// transmitter FSM
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	// bit positions within ep40 trigger word
	typedef enum logic [3:0] {
		TRIG_SEND         = 4'd0,
		TRIG_POP          = 4'd1,
		TRIG_CLEAR        = 4'd2,
		TRIG_ENABLE_LATCH = 4'd3
	} host_trig_t;

endpackage

//--- verilog/bt_rx_fifo.sv
/*
 Receive FIFO
 circular byte buffer between the UART receiver and the host,
 drops pushes when full and reports them as overflow
*/
`timescale 1ns/10ps
`include "bt_settings.svh"

module bt_rx_fifo import bt_pkg::*; #(
	parameter int DEPTH = `BT_RX_FIFO_DEPTH
) (
	input  logic       clock,
	input  logic       arst_n,
	input  logic       push,
	input  bt_byte_t   push_byte,
	input  logic       pop,
	output bt_byte_t   head_byte,
	output logic [7:0] count,
	output logic       empty,
	output logic       full,
	output logic       overflow_pulse
);

	localparam int AW = $clog2(DEPTH);

	bt_byte_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count_r;
	logic          push_ok;

	// full fifo drops the byte
	assign push_ok = push && !full;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			count_r        <= '0;
			overflow_pulse <= 1'b0;
		end else begin
			overflow_pulse <= push && full;
			// pointers wrap naturally, depth is a power of two
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves count alone
			case ({push_ok, pop})
				2'b10:   count_r <= count_r + 1'b1;
				2'b01:   count_r <= count_r - 1'b1;
				default: count_r <= count_r;
			endcase
		end
	end

	// storage, no reset
	always_ff @(posedge clock) begin
		if (push_ok)
			mem[wr_ptr] <= push_byte;
	end

	assign head_byte = mem[rd_ptr];
	assign count     = 8'(count_r);
	assign empty     = (count_r == '0);
	assign full      = (count_r == (AW + 1)'(DEPTH));

	// fill level stays in range
	a_count_range: assert property (@(posedge clock) disable iff (!arst_n)
		count_r <= (AW + 1)'(DEPTH));

	// endpoint block only pops a non-empty fifo
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!arst_n)
		pop |-> !empty);

endmodule

//--- verilog/bt_settings.svh
/*
 Bluetooth serial link settings
 compile-time UART bit period and receive FIFO depth
*/
`ifndef BT_SETTINGS_SVH
`define BT_SETTINGS_SVH

// clock cycles per uart bit
// 8 keeps simulation short, also 1 MHz clock at 125 kbaud
`define BT_CLKS_PER_BIT 8

// receive fifo entries, power of two
`define BT_RX_FIFO_DEPTH 8

`endif

//--- verilog/bt_uart_rx.sv
/*
 UART receiver for the Bluetooth module line
 synchronises fpga_rxd, confirms the start bit at mid-bit,
 samples eight data bits LSB first and checks the stop bit
*/
`timescale 1ns/10ps
`include "bt_settings.svh"

module bt_uart_rx import bt_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     fpga_rxd,
	output bt_byte_t rx_byte,
	output logic     rx_valid,
	output logic     frame_error_pulse
);

	localparam int CLKS = `BT_CLKS_PER_BIT;
	localparam int CW   = $clog2(CLKS);

	rx_state_t      state;
	logic [CW-1:0]  clk_cnt;
	logic [2:0]     bit_idx;
	logic           rxd_meta;
	logic           rxd_s;
	logic           half_done;
	logic           bit_done;
	bt_byte_t       shift_reg;

	// two-flop synchroniser, idle line is high
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= fpga_rxd;
			rxd_s    <= rxd_meta;
		end
	end

	// half period for start confirm, full period per bit
	assign half_done = (clk_cnt == CW'(CLKS / 2 - 1));
	assign bit_done  = (clk_cnt == CW'(CLKS - 1));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state             <= RX_IDLE;
			clk_cnt           <= '0;
			bit_idx           <= '0;
			rx_valid          <= 1'b0;
			frame_error_pulse <= 1'b0;
		end else begin
			// strobes last one cycle
			rx_valid          <= 1'b0;
			frame_error_pulse <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_s)
						state <= RX_START;
				end
				RX_START: begin
					if (half_done) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// high again at mid-bit means a glitch
						state   <= rxd_s ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						clk_cnt           <= '0;
						state             <= RX_IDLE;
						// low stop bit, report instead of a byte
						rx_valid          <= rxd_s;
						frame_error_pulse <= !rxd_s;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data bits arrive LSB first, shift in from the top
	always_ff @(posedge clock) begin
		if (state == RX_DATA && bit_done)
			shift_reg <= {rxd_s, shift_reg[7:1]};
	end

	assign rx_byte = shift_reg;

endmodule

//--- verilog/bt_uart_tx.sv
/*
 UART transmitter towards the Bluetooth module
 frames one byte as start bit, eight data bits LSB first and stop bit
*/
`timescale 1ns/10ps
`include "bt_settings.svh"

module bt_uart_tx import bt_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  logic     tx_start,
	input  bt_byte_t tx_byte,
	output logic     fpga_txd,
	output logic     tx_busy
);

	localparam int CLKS = `BT_CLKS_PER_BIT;
	localparam int CW   = $clog2(CLKS);

	tx_state_t     state;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	logic          bit_done;
	bt_byte_t      shift_reg;

	assign bit_done = (clk_cnt == CW'(CLKS - 1));

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= TX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			fpga_txd <= 1'b1;
			tx_busy  <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					fpga_txd <= 1'b1;
					clk_cnt  <= '0;
					if (tx_start) begin
						// start bit goes out right away
						state    <= TX_START;
						fpga_txd <= 1'b0;
						tx_busy  <= 1'b1;
					end
				end
				TX_START: begin
					if (bit_done) begin
						clk_cnt  <= '0;
						bit_idx  <= '0;
						state    <= TX_DATA;
						fpga_txd <= shift_reg[0];
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) begin
							state    <= TX_STOP;
							fpga_txd <= 1'b1;
						end else begin
							bit_idx  <= bit_idx + 1'b1;
							// next bit, shift happens on this edge too
							fpga_txd <= shift_reg[1];
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				TX_STOP: begin
					if (bit_done) begin
						clk_cnt <= '0;
						state   <= TX_IDLE;
						tx_busy <= 1'b0;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// byte captured at start, shifted right per data bit
	always_ff @(posedge clock) begin
		if (state == TX_IDLE && tx_start)
			shift_reg <= tx_byte;
		else if (state == TX_DATA && bit_done)
			shift_reg <= shift_reg >> 1;
	end

	// endpoint block holds sends back while busy
	a_no_start_busy: assert property (@(posedge clock) disable iff (!arst_n)
		tx_start |-> !tx_busy);

	// line idles high between frames
	a_idle_high: assert property (@(posedge clock) disable iff (!arst_n)
		(state == TX_IDLE) |-> fpga_txd);

endmodule

//--- verilog/fpga_bluetooth_connection.sv
/*
 Bluetooth serial link top level
 UART receiver feeds the receive FIFO, the host endpoint block drains it
 and drives the UART transmitter
*/
`timescale 1ns/10ps

module fpga_bluetooth_connection import bt_pkg::*; (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        bt_state,
	input  logic        fpga_rxd,
	output logic        bt_enable,
	output logic        fpga_txd,
	input  logic [15:0] ep01_wire_in,
	input  logic [15:0] ep40_trig_in,
	output logic [15:0] ep20_wire_out,
	output logic [15:0] ep21_wire_out
);

	bt_byte_t   rx_byte;
	logic       rx_valid;
	logic       frame_error_pulse;
	bt_byte_t   head_byte;
	logic [7:0] count;
	logic       empty;
	logic       full;
	logic       overflow_pulse;
	logic       pop;
	bt_byte_t   tx_byte;
	logic       tx_start;
	logic       tx_busy;

	// producer
	bt_uart_rx u_uart_rx (
		.clock             (clock),
		.arst_n            (arst_n),
		.fpga_rxd          (fpga_rxd),
		.rx_byte           (rx_byte),
		.rx_valid          (rx_valid),
		.frame_error_pulse (frame_error_pulse)
	);

	// buffer
	bt_rx_fifo u_rx_fifo (
		.clock          (clock),
		.arst_n         (arst_n),
		.push           (rx_valid),
		.push_byte      (rx_byte),
		.pop            (pop),
		.head_byte      (head_byte),
		.count          (count),
		.empty          (empty),
		.full           (full),
		.overflow_pulse (overflow_pulse)
	);

	// consumer, host side
	bt_host_endpoints u_host_endpoints (
		.clock             (clock),
		.arst_n            (arst_n),
		.ep01_wire_in      (ep01_wire_in),
		.ep40_trig_in      (ep40_trig_in),
		.bt_state          (bt_state),
		.head_byte         (head_byte),
		.count             (count),
		.empty             (empty),
		.full              (full),
		.overflow_pulse    (overflow_pulse),
		.frame_error_pulse (frame_error_pulse),
		.tx_busy           (tx_busy),
		.pop               (pop),
		.tx_start          (tx_start),
		.tx_byte           (tx_byte),
		.bt_enable         (bt_enable),
		.ep20_wire_out     (ep20_wire_out),
		.ep21_wire_out     (ep21_wire_out)
	);

	bt_uart_tx u_uart_tx (
		.clock    (clock),
		.arst_n   (arst_n),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.fpga_txd (fpga_txd),
		.tx_busy  (tx_busy)
	);

endmodule
